// File: src/cart_pkg.sv
/*
 * Shared widths, address constants, bus structs and enums for the
 * cartridge load and mapping path. Every RTL block and the testbench
 * refer to these through cart_pkg:: scoped names.
 */
package cart_pkg;

	// Download index decode
	localparam logic [5:0]  ROM_INDEX_MAX      = 6'h01;    // Index 0 = BIOS, 1 = cart
	localparam int          CART_INDEX_BIT     = 6;
	localparam logic [24:0] HEADER_REGION_ADDR = 25'h1F0;  // Region letter in header

	// Region reset pulse
	localparam int REGION_HOLD_CYCLES = 1024;
	localparam int HOLD_CNT_W         = $clog2(REGION_HOLD_CYCLES + 1);

	// Mapper and SDRAM layout
	localparam int         BANK_COUNT = 8;
	localparam logic [7:0] BIOS_BASE  = 8'h78;             // BIOS at F00000 (bytes)

	// Upper bit doubles as the PAL flag
	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	typedef logic [4:0]   bank_t;
	typedef logic [15:0]  word_t;
	typedef logic [23:1]  cpu_addr_t;    // CPU word address
	typedef logic [23:0]  sdram_addr_t;  // SDRAM word address
	typedef logic [23:13] rom_mask_t;    // Mask for 8 KB granules

	typedef struct packed {
		logic        download;
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		word_t       data;
	} ioctl_bus_t;

	typedef struct packed {
		cpu_addr_t addr;
		word_t     wdata;
		logic      rnw;
		logic      page_n;  // Page register select, active low
	} cpu_bus_t;

	typedef struct packed {
		sdram_addr_t addr;
		word_t       data;
		logic        write;
	} mem_load_t;

	typedef struct packed {
		logic      rom_load;
		logic      cart_mode;
		rom_mask_t rom_mask;
		region_t   hdr_region;
		logic      hdr_seen;
	} rom_info_t;

endpackage

// File: src/download_snoop.sv
/*
 * Watches the host download bus while a ROM image streams in.
 * Builds the ROM size mask from the highest address seen, latches
 * whether the image is a cartridge or a BIOS, and picks up the
 * region letter from the cartridge header.
 */
`timescale 1ns/1ps

module download_snoop (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  cart_pkg::ioctl_bus_t   ioctl,
	output cart_pkg::rom_info_t    info
);

	logic                rom_load;
	logic                rom_strobe;
	logic                is_cart;
	cart_pkg::rom_mask_t rom_mask;
	cart_pkg::region_t   hdr_region;
	logic                cart_mode;
	logic                hdr_seen;

	assign rom_load   = ioctl.download && (ioctl.index[5:0] <= cart_pkg::ROM_INDEX_MAX);
	assign rom_strobe = rom_load && ioctl.wr;  // One strobe per word
	assign is_cart    = ioctl.index[cart_pkg::CART_INDEX_BIT];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_mode  <= 1'b0;
			rom_mask   <= '0;
			hdr_region <= cart_pkg::REGION_JP;
			hdr_seen   <= 1'b0;
		end else if (rom_strobe) begin
			cart_mode <= is_cart;
			if (is_cart) begin
				if (ioctl.addr == '0) rom_mask <= '0;  // New image starts over
				else rom_mask <= rom_mask | ioctl.addr[23:13];
			end
			if (ioctl.addr == cart_pkg::HEADER_REGION_ADDR) begin
				hdr_seen <= 1'b1;
				if (ioctl.data[7:0] == "J") hdr_region <= cart_pkg::REGION_JP;
				else if (ioctl.data[7:0] == "U") hdr_region <= cart_pkg::REGION_US;
				else hdr_region <= cart_pkg::REGION_EU;  // Anything else is treated as PAL
			end
		end
	end

	assign info.rom_load   = rom_load;
	assign info.cart_mode  = cart_mode;
	assign info.rom_mask   = rom_mask;
	assign info.hdr_region = hdr_region;
	assign info.hdr_seen   = hdr_seen;

endmodule

// File: src/region_ctrl.sv
/*
 * Active region selection. The menu option either forces a region or
 * defers to the cartridge header. Any change of the selected region
 * restarts a hold counter that keeps region_set high, so the console
 * sits in reset while it switches video standard.
 */
`timescale 1ns/1ps

module region_ctrl (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  cart_pkg::rom_info_t  info,
	input  logic [1:0]           region_opt,
	output cart_pkg::region_t    region,
	output logic                 pal,
	output logic                 region_set
);

	cart_pkg::region_t               region_sel;
	logic [cart_pkg::HOLD_CNT_W-1:0] hold_cnt;
	logic                            hold_done;

	// Option 0 is automatic, 1..3 force JP/US/EU
	always_comb begin
		case (region_opt)
			2'd1:    region_sel = cart_pkg::REGION_JP;
			2'd2:    region_sel = cart_pkg::REGION_US;
			2'd3:    region_sel = cart_pkg::REGION_EU;
			default: region_sel = info.hdr_seen ? info.hdr_region : cart_pkg::REGION_JP;
		endcase
	end

	assign hold_done = (hold_cnt == cart_pkg::HOLD_CNT_W'(cart_pkg::REGION_HOLD_CYCLES));

	////////////////////////////////////////////////////////////////////////
	// Region register and reset hold
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			region     <= cart_pkg::REGION_JP;
			hold_cnt   <= '0;
			region_set <= 1'b1;  // Start-up counts as a region change
		end else begin
			region     <= region_sel;
			region_set <= !hold_done;
			if (region != region_sel) hold_cnt <= '0;
			else if (!hold_done) hold_cnt <= hold_cnt + 1'b1;
		end
	end

	assign pal = region[1];

endmodule

// File: src/bank_mapper.sv
/*
 * Large-ROM mapper. Eight 5-bit bank registers select which 512 KB
 * page of the ROM appears in each CPU window. The CPU writes them
 * through the page register strobe, and only when the ROM is bigger
 * than 4 MB. The translated address is masked to the ROM size.
 */
`timescale 1ns/1ps

module bank_mapper (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  cart_pkg::rom_info_t  info,
	input  cart_pkg::cpu_bus_t   cpu,
	output cart_pkg::cpu_addr_t  rom_va,
	output cart_pkg::word_t      page_di
);

	cart_pkg::bank_t bank_reg [cart_pkg::BANK_COUNT];
	logic            page_n_q;
	logic            page_fall;
	logic            large_rom;
	logic            bank_wr;

	assign page_fall = page_n_q && !cpu.page_n;      // Access starts
	assign large_rom = |info.rom_mask[23:22];        // Over 4 MB
	assign bank_wr   = page_fall && !cpu.rnw && (cpu.addr[3:1] != 3'd0) && large_rom;

	always_ff @(posedge clk_sys) begin
		if (reset) page_n_q <= 1'b1;
		else page_n_q <= cpu.page_n;
	end

	////////////////////////////////////////////////////////////////////////
	// Bank registers
	always_ff @(posedge clk_sys) begin
		if (reset || info.rom_load) begin
			// Identity map until software says otherwise
			for (int i = 0; i < cart_pkg::BANK_COUNT; i++) begin
				bank_reg[i] <= cart_pkg::bank_t'(i);
			end
		end else if (bank_wr) begin
			bank_reg[cpu.addr[3:1]] <= cpu.wdata[4:0];  // Register 0 is fixed
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Address translation
	// Window select in bits 21..19, offset in 18..1
	assign rom_va = {bank_reg[cpu.addr[21:19]], cpu.addr[18:1]}
		& {info.rom_mask, 12'hFFF};  // Low 12 bits always pass

	// Nothing readable behind the page registers
	assign page_di = '1;

endmodule

// File: src/sdram_map.sv
/*
 * SDRAM side of the loader. Forms the word address for ROM reads and
 * for download writes, in either the cartridge or the BIOS layout,
 * swaps the download bytes into memory order and holds the host off
 * with ioctl_wait until the memory has taken each word.
 */
`timescale 1ns/1ps

module sdram_map (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  cart_pkg::rom_info_t    info,
	input  cart_pkg::ioctl_bus_t   ioctl,
	input  cart_pkg::cpu_addr_t    rom_va,
	input  cart_pkg::cpu_addr_t    cpu_addr,
	input  logic                   mem_busy,
	output logic                   ioctl_wait,
	output cart_pkg::mem_load_t    mem_load,
	output cart_pkg::sdram_addr_t  rom_mem_addr
);

	logic busy_q;
	logic busy_fall;

	assign busy_fall = busy_q && !mem_busy;  // Memory finished the write

	////////////////////////////////////////////////////////////////////////
	// Download flow control
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			busy_q     <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			busy_q <= mem_busy;
			if (info.rom_load && ioctl.wr) ioctl_wait <= 1'b1;
			if (busy_fall) ioctl_wait <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Address layouts
	// Cart ROM at 000000-7FFFFF, BIOS at F00000 (byte addresses)
	assign rom_mem_addr = info.cart_mode ? {2'b00, rom_va[22:1]}
		: {cart_pkg::BIOS_BASE, cpu_addr[16:1]};

	always_comb begin
		mem_load.addr  = info.cart_mode ? {2'b00, ioctl.addr[22:1]}
			: {cart_pkg::BIOS_BASE, ioctl.addr[16:1]};
		mem_load.data  = {ioctl.data[7:0], ioctl.data[15:8]};  // Host sends little endian
		mem_load.write = info.rom_load && ioctl_wait;
	end

endmodule

// File: src/cart_loader_top.sv
/*
 * Top level of the cartridge load and mapping path. Connects the
 * download snooper, the region controller, the bank mapper and the
 * SDRAM address block. Drive the download bus, the CPU bus, the menu
 * region option and the memory busy level from outside.
 */
`timescale 1ns/1ps

module cart_loader_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  cart_pkg::ioctl_bus_t   ioctl,
	input  cart_pkg::cpu_bus_t     cpu,
	input  logic [1:0]             region_opt,
	input  logic                   mem_busy,
	output cart_pkg::region_t      region,
	output logic                   pal,
	output logic                   region_set,
	output logic                   ioctl_wait,
	output cart_pkg::mem_load_t    mem_load,
	output cart_pkg::sdram_addr_t  rom_mem_addr,
	output cart_pkg::word_t        page_di
);

	cart_pkg::rom_info_t info;    // Snooped image properties
	cart_pkg::cpu_addr_t rom_va;  // Banked and masked ROM address

	download_snoop u_snoop (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ioctl   (ioctl),
		.info    (info)
	);

	region_ctrl u_region (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.info       (info),
		.region_opt (region_opt),
		.region     (region),
		.pal        (pal),
		.region_set (region_set)
	);

	bank_mapper u_mapper (
		.clk_sys (clk_sys),
		.reset   (reset),
		.info    (info),
		.cpu     (cpu),
		.rom_va  (rom_va),
		.page_di (page_di)
	);

	sdram_map u_sdram (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.info         (info),
		.ioctl        (ioctl),
		.rom_va       (rom_va),
		.cpu_addr     (cpu.addr),
		.mem_busy     (mem_busy),
		.ioctl_wait   (ioctl_wait),
		.mem_load     (mem_load),
		.rom_mem_addr (rom_mem_addr)
	);

endmodule

// File: verification/cart_loader_tb.sv
/*
 * Testbench for the cartridge loader top level. Operations and their
 * expected values come from the cases file, one per line. SDRAM busy
 * time is modelled with a random delay after every download word.
 */
`timescale 1ns/1ps

module cart_loader_tb;

	localparam string CASES_FILE = "verification/cart_loader_cases.txt";
	localparam int    WAIT_LIMIT = 32;  // Cycles allowed for ioctl_wait to drop

	logic                  clk_sys = 1'b0;
	logic                  reset;
	cart_pkg::ioctl_bus_t  ioctl;
	cart_pkg::cpu_bus_t    cpu;
	logic [1:0]            region_opt;
	logic                  mem_busy;
	cart_pkg::region_t     region;
	logic                  pal;
	logic                  region_set;
	logic                  ioctl_wait;
	cart_pkg::mem_load_t   mem_load;
	cart_pkg::sdram_addr_t rom_mem_addr;
	cart_pkg::word_t       page_di;

	string  case_lines[$];
	bit     cases_loaded = 1'b0;
	integer seed = 32'h5bbd;
	int     value_errors = 0;
	int     other_errors = 0;
	int     run_len = 0;     // Current region_set pulse
	int     last_pulse = 0;  // Length of the last finished pulse

	cart_loader_top uut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ioctl        (ioctl),
		.cpu          (cpu),
		.region_opt   (region_opt),
		.mem_busy     (mem_busy),
		.region       (region),
		.pal          (pal),
		.region_set   (region_set),
		.ioctl_wait   (ioctl_wait),
		.mem_load     (mem_load),
		.rom_mem_addr (rom_mem_addr),
		.page_di      (page_di)
	);

	always #2 clk_sys = ~clk_sys;

	// Pulse length in cycles, sampled where outputs are stable
	always @(negedge clk_sys) begin
		if (region_set === 1'b1) run_len <= run_len + 1;
		else if (run_len != 0) begin
			last_pulse <= run_len;
			run_len    <= 0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	task automatic check_region(input string name, input cart_pkg::region_t exp,
		input cart_pkg::region_t act);
		if (act !== exp) begin
			$display("Error at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_addr(input string name, input cart_pkg::sdram_addr_t exp,
		input cart_pkg::sdram_addr_t act);
		if (act !== exp) begin
			$display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_word(input string name, input cart_pkg::word_t exp,
		input cart_pkg::word_t act);
		if (act !== exp) begin
			$display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error at %0d ns: %s expected %b, got %b", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("Error at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
			value_errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus operations
	task automatic load_word(input logic [7:0] index, input logic [24:0] addr,
		input cart_pkg::word_t data, input cart_pkg::sdram_addr_t exp_addr,
		input cart_pkg::word_t exp_data);
		int busy_len;
		int waited;
		@(negedge clk_sys);
		ioctl.download = 1'b1;
		ioctl.index    = index;
		ioctl.addr     = addr;
		ioctl.data     = data;
		ioctl.wr       = 1'b1;  // One strobe per word
		@(negedge clk_sys);
		check_addr("mem_load.addr", exp_addr, mem_load.addr);
		check_word("mem_load.data", exp_data, mem_load.data);
		check_bit("mem_load.write", 1'b1, mem_load.write);
		check_bit("ioctl_wait", 1'b1, ioctl_wait);
		ioctl.wr = 1'b0;
		busy_len = 1 + ($unsigned($random(seed)) % 6);
		mem_busy = 1'b1;
		repeat (busy_len) begin
			@(negedge clk_sys);
			check_bit("ioctl_wait", 1'b1, ioctl_wait);  // Held off by memory
			check_bit("mem_load.write", 1'b1, mem_load.write);
		end
		mem_busy = 1'b0;
		waited = 0;
		while (ioctl_wait !== 1'b0 && waited < WAIT_LIMIT) begin
			@(negedge clk_sys);
			waited++;
		end
		if (ioctl_wait !== 1'b0) begin
			$display("ioctl_wait stayed high after mem_busy fell at %0d ns", $time);
			other_errors++;
		end else begin
			check_bit("mem_load.write", 1'b0, mem_load.write);  // Follows ioctl_wait down
		end
	endtask

	task automatic page_access(input logic read, input logic [23:0] addr,
		input cart_pkg::word_t value);
		@(negedge clk_sys);
		cpu.addr   = addr[23:1];
		cpu.wdata  = read ? 16'h0000 : value;
		cpu.rnw    = read;
		cpu.page_n = 1'b0;
		@(negedge clk_sys);
		if (read) check_word("page_di", value, page_di);
		cpu.page_n = 1'b1;
		cpu.rnw    = 1'b1;
	endtask

	task automatic wait_hold_end;
		int cycles;
		cycles = 0;
		while (region_set !== 1'b0 && cycles < 2 * cart_pkg::REGION_HOLD_CYCLES + 16) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (region_set !== 1'b0) begin
			$display("region_set did not return low at %0d ns", $time);
			other_errors++;
		end
		@(negedge clk_sys);  // Let the pulse monitor record
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus from the cases file
	initial begin : stimulus
		int          fd;
		int          n;
		string       line;
		logic [7:0]  op;
		logic [31:0] f [5];
		reset      = 1'b1;
		ioctl      = '0;
		cpu        = '0;
		cpu.page_n = 1'b1;
		cpu.rnw    = 1'b1;
		region_opt = 2'd0;
		mem_busy   = 1'b0;
		fd = $fopen(CASES_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the cases file %s", CASES_FILE);
			other_errors++;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
					case_lines.push_back(line);
				end
			end
			$fclose(fd);
		end
		cases_loaded = 1'b1;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		check_bit("ioctl_wait", 1'b0, ioctl_wait);  // Idle after reset
		check_bit("mem_load.write", 1'b0, mem_load.write);
		reset = 1'b0;
		foreach (case_lines[i]) begin
			n = $sscanf(case_lines[i], "%c %h %h %h %h %h", op, f[0], f[1], f[2], f[3], f[4]);
			case (op)
				"S": wait_hold_end();
				"H": begin
					wait_hold_end();
					check_count("region_set pulse length", int'(f[0]), last_pulse);
				end
				"L": load_word(f[0][7:0], f[1][24:0], f[2][15:0], f[3][23:0], f[4][15:0]);
				"E": begin
					@(negedge clk_sys);
					ioctl = '0;  // Download finished
				end
				"O": begin
					@(negedge clk_sys);
					region_opt = f[0][1:0];
				end
				"G": begin
					@(negedge clk_sys);
					check_region("region", cart_pkg::region_t'(f[0][1:0]), region);
					check_bit("pal", f[1][0], pal);
				end
				"A": begin
					@(negedge clk_sys);
					cpu.addr = f[0][23:1];
					@(negedge clk_sys);
					check_addr("rom_mem_addr", f[1][23:0], rom_mem_addr);
				end
				"W": page_access(1'b0, f[0][23:0], f[1][15:0]);
				"R": page_access(1'b1, f[0][23:0], f[1][15:0]);
				default: begin
					$display("Unknown operation in cases line %0d: %s", i, case_lines[i]);
					other_errors++;
				end
			endcase
		end
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// Watchdog sized from the number of cases
	initial begin : watchdog
		int limit;
		wait (cases_loaded);
		limit = case_lines.size() * 40 + cart_pkg::REGION_HOLD_CYCLES * 4;
		repeat (limit) @(posedge clk_sys);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: verification/cart_loader_cases.txt
# L index addr data exp_mem_addr exp_mem_data | E end download | S wait out region_set
# H pulse_len | O region_opt | G region pal | A cpu_byte_addr exp_rom_mem_addr
# W cpu_byte_addr data (page write) | R cpu_byte_addr exp_page_di (page read), all hex
S
L 41 000000 1234 000000 3412
L 41 0001f0 0055 0000f8 5500
L 41 5ffffe abcd 2fffff cdab
E
H 400
G 1 0
O 3
G 2 1
O 0
G 1 0
A 1abcde 0d5e6f
A 3abcde 0d5e6f
A 281234 04091a
W a1300a 000c
A 281234 20091a
R a1300a ffff
A 281234 20091a
L 41 000000 5a5a 000000 5a5a
L 41 1ffffe 0102 0fffff 0201
E
A 281234 04091a
W a1300a 000c
A 281234 04091a
L 00 000000 1122 780000 2211
L 00 01fffe beef 78ffff efbe
E
A 012346 7891a3

// File: cart_loader.f
src/cart_pkg.sv
src/download_snoop.sv
src/region_ctrl.sv
src/bank_mapper.sv
src/sdram_map.sv
src/cart_loader_top.sv
verification/cart_loader_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the cartridge loader testbench with Verilator and run it.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cart_loader_tb \
	-f cart_loader.f --Mdir obj_dir -o cart_loader_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cart_loader_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
